/* Makefile */
# Verilator build and run for the data-bus subsystem

VERILATOR ?= verilator
TOP       ?= dbus_subsystem_tb
FILELIST  ?= dbus_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dbus_subsystem.f */
design/dbus_pkg.sv
design/uncached_bridge.sv
design/axi_sram_slave.sv
design/dbus_subsystem_top.sv
testbench/dbus_subsystem_assert.sv
testbench/dbus_checker.sv
testbench/dbus_subsystem_tb.sv

/* design/axi_sram_slave.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_sram_slave #(
	parameter int MEM_WORDS  = 256,
	parameter int RESP_DELAY = 2
) (
	input  logic              clk,
	input  logic              rst,
	input  dbus_pkg::addr_t   axi_araddr,
	input  dbus_pkg::axi_id_t axi_arid,
	input  logic              axi_arvalid,
	output logic              axi_arready,
	input  dbus_pkg::addr_t   axi_awaddr,
	input  dbus_pkg::axi_id_t axi_awid,
	input  logic              axi_awvalid,
	output logic              axi_awready,
	input  dbus_pkg::word_t   axi_wdata,
	input  dbus_pkg::strb_t   axi_wstrb,
	input  logic              axi_wlast,
	input  logic              axi_wvalid,
	output logic              axi_wready,
	output dbus_pkg::word_t   axi_rdata,
	output dbus_pkg::resp_t   axi_rresp,
	output dbus_pkg::axi_id_t axi_rid,
	output logic              axi_rvalid,
	input  logic              axi_rready,
	output dbus_pkg::resp_t   axi_bresp,
	output dbus_pkg::axi_id_t axi_bid,
	output logic              axi_bvalid,
	input  logic              axi_bready
);

	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam int CNT_W = (RESP_DELAY > 0) ? $clog2(RESP_DELAY + 1) : 1;

	typedef enum logic [2:0] {
		S_IDLE,
		S_RDATA,
		S_WDATA,
		S_WCOMMIT,
		S_WRESP
	} slave_state_t;

	slave_state_t state, state_d;

	logic [CNT_W-1:0] cnt;
	logic             cnt_en;
	logic             dly_done;

	dbus_pkg::word_t   mem [MEM_WORDS];
	dbus_pkg::addr_t   addr_q;
	dbus_pkg::axi_id_t id_q;
	dbus_pkg::word_t   wdata_q;
	dbus_pkg::strb_t   wstrb_q;
	logic              wlast_q;

	logic             in_range;
	logic             wr_ok;
	logic [IDX_W-1:0] idx;

	assign idx      = addr_q[IDX_W+1:2];
	assign in_range = addr_q < (dbus_pkg::addr_t'(MEM_WORDS) << 2);
	// Only a proper last beat inside the array is committed
	assign wr_ok    = in_range & wlast_q;
	assign dly_done = (cnt == CNT_W'(RESP_DELAY));

	assign axi_rdata = in_range ? mem[idx] : '0;
	assign axi_rresp = in_range ? dbus_pkg::RESP_OKAY : dbus_pkg::RESP_SLVERR;
	assign axi_bresp = wr_ok ? dbus_pkg::RESP_OKAY : dbus_pkg::RESP_SLVERR;
	assign axi_rid   = id_q;
	assign axi_bid   = id_q;

	always_comb begin
		state_d     = state;
		cnt_en      = 1'b0;
		axi_arready = 1'b0;
		axi_awready = 1'b0;
		axi_wready  = 1'b0;
		axi_rvalid  = 1'b0;
		axi_bvalid  = 1'b0;

		case (state)
			// Reads win when both address channels are valid
			S_IDLE: begin
				if (axi_arvalid) begin
					cnt_en = 1'b1;
					if (dly_done) begin
						axi_arready = 1'b1;
						state_d     = S_RDATA;
					end
				end else if (axi_awvalid) begin
					cnt_en = 1'b1;
					if (dly_done) begin
						axi_awready = 1'b1;
						state_d     = S_WDATA;
					end
				end
			end
			S_RDATA: begin
				cnt_en = 1'b1;
				if (dly_done) begin
					axi_rvalid = 1'b1;
					if (axi_rready) state_d = S_IDLE;
				end
			end
			S_WDATA: begin
				if (axi_wvalid) begin
					cnt_en = 1'b1;
					if (dly_done) begin
						axi_wready = 1'b1;
						state_d    = S_WCOMMIT;
					end
				end
			end
			S_WCOMMIT: begin
				state_d = S_WRESP;
			end
			S_WRESP: begin
				cnt_en = 1'b1;
				if (dly_done) begin
					axi_bvalid = 1'b1;
					if (axi_bready) state_d = S_IDLE;
				end
			end
			default: begin
				state_d = S_IDLE;
			end
		endcase
	end

	// Delay restarts on every state change
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			cnt   <= '0;
		end else begin
			state <= state_d;
			if (state_d != state) begin
				cnt <= '0;
			end else if (cnt_en && !dly_done) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (axi_arready) begin
			addr_q <= axi_araddr;
			id_q   <= axi_arid;
		end else if (axi_awready) begin
			addr_q <= axi_awaddr;
			id_q   <= axi_awid;
		end
		if (axi_wready) begin
			wdata_q <= axi_wdata;
			wstrb_q <= axi_wstrb;
			wlast_q <= axi_wlast;
		end
	end

	// Byte-merged write one cycle after the data beat
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (state == S_WCOMMIT && wr_ok) begin
			for (int b = 0; b < dbus_pkg::STRB_W; b++) begin
				if (wstrb_q[b]) mem[idx][8*b +: 8] <= wdata_q[8*b +: 8];
			end
		end
	end

endmodule

`default_nettype wire

/* design/dbus_pkg.sv */
`default_nettype none

package dbus_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int ID_W   = 4;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] word_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [ID_W-1:0]   axi_id_t;

	// AXI response codes
	typedef logic [1:0] resp_t;
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// Uncached bridge FSM
	typedef enum logic [2:0] {
		IDLE,
		READ_ADDR,
		READ_DATA,
		WRITE_ADDR,
		WRITE_DATA,
		WRITE_RESP,
		FINISHED
	} bridge_state_t;

endpackage

`default_nettype wire

/* design/dbus_subsystem_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dbus_subsystem_top #(
	parameter int MEM_WORDS  = 256,
	parameter int RESP_DELAY = 2
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            req,
	input  logic            we,
	input  dbus_pkg::addr_t addr,
	input  dbus_pkg::word_t wdata,
	input  dbus_pkg::strb_t wstrb,
	output logic            stall,
	output dbus_pkg::word_t rdata,
	output logic            done,
	output logic            err
);

	// AXI between bridge and SRAM
	dbus_pkg::addr_t   axi_araddr;
	dbus_pkg::axi_id_t axi_arid;
	logic              axi_arvalid;
	logic              axi_arready;
	dbus_pkg::addr_t   axi_awaddr;
	dbus_pkg::axi_id_t axi_awid;
	logic              axi_awvalid;
	logic              axi_awready;
	dbus_pkg::word_t   axi_wdata;
	dbus_pkg::strb_t   axi_wstrb;
	logic              axi_wlast;
	logic              axi_wvalid;
	logic              axi_wready;
	dbus_pkg::word_t   axi_rdata;
	dbus_pkg::resp_t   axi_rresp;
	dbus_pkg::axi_id_t axi_rid;
	logic              axi_rvalid;
	logic              axi_rready;
	dbus_pkg::resp_t   axi_bresp;
	dbus_pkg::axi_id_t axi_bid;
	logic              axi_bvalid;
	logic              axi_bready;

	uncached_bridge uncached_bridge_i (
		.clk         (clk),
		.rst         (rst),
		.req         (req),
		.we          (we),
		.addr        (addr),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.stall       (stall),
		.done        (done),
		.err         (err),
		.rdata       (rdata),
		.axi_araddr  (axi_araddr),
		.axi_arid    (axi_arid),
		.axi_arvalid (axi_arvalid),
		.axi_arready (axi_arready),
		.axi_awaddr  (axi_awaddr),
		.axi_awid    (axi_awid),
		.axi_awvalid (axi_awvalid),
		.axi_awready (axi_awready),
		.axi_wdata   (axi_wdata),
		.axi_wstrb   (axi_wstrb),
		.axi_wlast   (axi_wlast),
		.axi_wvalid  (axi_wvalid),
		.axi_wready  (axi_wready),
		.axi_rdata   (axi_rdata),
		.axi_rresp   (axi_rresp),
		.axi_rid     (axi_rid),
		.axi_rvalid  (axi_rvalid),
		.axi_rready  (axi_rready),
		.axi_bresp   (axi_bresp),
		.axi_bid     (axi_bid),
		.axi_bvalid  (axi_bvalid),
		.axi_bready  (axi_bready)
	);

	axi_sram_slave #(
		.MEM_WORDS  (MEM_WORDS),
		.RESP_DELAY (RESP_DELAY)
	) axi_sram_slave_i (
		.clk         (clk),
		.rst         (rst),
		.axi_araddr  (axi_araddr),
		.axi_arid    (axi_arid),
		.axi_arvalid (axi_arvalid),
		.axi_arready (axi_arready),
		.axi_awaddr  (axi_awaddr),
		.axi_awid    (axi_awid),
		.axi_awvalid (axi_awvalid),
		.axi_awready (axi_awready),
		.axi_wdata   (axi_wdata),
		.axi_wstrb   (axi_wstrb),
		.axi_wlast   (axi_wlast),
		.axi_wvalid  (axi_wvalid),
		.axi_wready  (axi_wready),
		.axi_rdata   (axi_rdata),
		.axi_rresp   (axi_rresp),
		.axi_rid     (axi_rid),
		.axi_rvalid  (axi_rvalid),
		.axi_rready  (axi_rready),
		.axi_bresp   (axi_bresp),
		.axi_bid     (axi_bid),
		.axi_bvalid  (axi_bvalid),
		.axi_bready  (axi_bready)
	);

endmodule

`default_nettype wire

/* design/uncached_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module uncached_bridge (
	input  logic                    clk,
	input  logic                    rst,
	// CPU side
	input  logic                    req,
	input  logic                    we,
	input  dbus_pkg::addr_t         addr,
	input  dbus_pkg::word_t         wdata,
	input  dbus_pkg::strb_t         wstrb,
	output logic                    stall,
	output logic                    done,
	output logic                    err,
	output dbus_pkg::word_t         rdata,
	// AXI read address
	output dbus_pkg::addr_t         axi_araddr,
	output dbus_pkg::axi_id_t       axi_arid,
	output logic                    axi_arvalid,
	input  logic                    axi_arready,
	// AXI write address
	output dbus_pkg::addr_t         axi_awaddr,
	output dbus_pkg::axi_id_t       axi_awid,
	output logic                    axi_awvalid,
	input  logic                    axi_awready,
	// AXI write data
	output dbus_pkg::word_t         axi_wdata,
	output dbus_pkg::strb_t         axi_wstrb,
	output logic                    axi_wlast,
	output logic                    axi_wvalid,
	input  logic                    axi_wready,
	// AXI read data
	input  dbus_pkg::word_t         axi_rdata,
	input  dbus_pkg::resp_t         axi_rresp,
	input  dbus_pkg::axi_id_t       axi_rid,
	input  logic                    axi_rvalid,
	output logic                    axi_rready,
	// AXI write response
	input  dbus_pkg::resp_t         axi_bresp,
	input  dbus_pkg::axi_id_t       axi_bid,
	input  logic                    axi_bvalid,
	output logic                    axi_bready
);

	dbus_pkg::bridge_state_t state, state_d;

	// Request held for the whole transaction
	dbus_pkg::addr_t pipe_addr;
	dbus_pkg::word_t pipe_wdata;
	dbus_pkg::strb_t pipe_wstrb;

	dbus_pkg::word_t rdata_q;
	logic            err_q;

	// Single outstanding transaction, so IDs stay at zero
	assign axi_arid  = '0;
	assign axi_awid  = '0;
	assign axi_wlast = 1'b1;

	assign axi_araddr = pipe_addr;
	assign axi_awaddr = pipe_addr;
	assign axi_wdata  = pipe_wdata;
	assign axi_wstrb  = pipe_wstrb;

	assign stall = (state != dbus_pkg::IDLE);
	assign done  = (state == dbus_pkg::FINISHED);
	assign err   = done & err_q;
	assign rdata = rdata_q;

	always_comb begin
		state_d     = state;
		axi_arvalid = 1'b0;
		axi_awvalid = 1'b0;
		axi_wvalid  = 1'b0;
		axi_rready  = 1'b0;
		axi_bready  = 1'b0;

		case (state)
			dbus_pkg::IDLE: begin
				if (req) begin
					state_d = we ? dbus_pkg::WRITE_ADDR : dbus_pkg::READ_ADDR;
				end
			end
			dbus_pkg::READ_ADDR: begin
				axi_arvalid = 1'b1;
				if (axi_arready) state_d = dbus_pkg::READ_DATA;
			end
			dbus_pkg::READ_DATA: begin
				axi_rready = 1'b1;
				if (axi_rvalid) state_d = dbus_pkg::FINISHED;
			end
			dbus_pkg::WRITE_ADDR: begin
				axi_awvalid = 1'b1;
				if (axi_awready) state_d = dbus_pkg::WRITE_DATA;
			end
			// Data goes out only once the address is taken
			dbus_pkg::WRITE_DATA: begin
				axi_wvalid = 1'b1;
				if (axi_wready) state_d = dbus_pkg::WRITE_RESP;
			end
			dbus_pkg::WRITE_RESP: begin
				axi_bready = 1'b1;
				if (axi_bvalid) state_d = dbus_pkg::FINISHED;
			end
			dbus_pkg::FINISHED: begin
				state_d = dbus_pkg::IDLE;
			end
			default: begin
				state_d = dbus_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= dbus_pkg::IDLE;
		end else begin
			state <= state_d;
		end
	end

	always_ff @(posedge clk) begin
		if (state == dbus_pkg::IDLE && req) begin
			pipe_addr  <= addr;
			pipe_wdata <= wdata;
			pipe_wstrb <= wstrb;
		end
	end

	// Response capture
	always_ff @(posedge clk) begin
		if (state == dbus_pkg::READ_DATA && axi_rvalid) begin
			rdata_q <= axi_rdata;
		end
	end

	// A stray ID also counts as an error
	always_ff @(posedge clk) begin
		if (rst) begin
			err_q <= 1'b0;
		end else if (state == dbus_pkg::READ_DATA && axi_rvalid) begin
			err_q <= (axi_rresp != dbus_pkg::RESP_OKAY) || (axi_rid != '0);
		end else if (state == dbus_pkg::WRITE_RESP && axi_bvalid) begin
			err_q <= (axi_bresp != dbus_pkg::RESP_OKAY) || (axi_bid != '0);
		end
	end

endmodule

`default_nettype wire

/* testbench/dbus_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module dbus_checker #(
	parameter int MEM_WORDS  = 256,
	parameter int RESP_DELAY = 2
) (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire logic            req,
	input  wire logic            we,
	input  wire dbus_pkg::addr_t addr,
	input  wire dbus_pkg::word_t wdata,
	input  wire dbus_pkg::strb_t wstrb,
	input  wire logic            stall,
	input  wire logic            done,
	input  wire dbus_pkg::word_t rdata,
	input  wire logic            err,
	// Expected values from the stimulus table
	input  wire logic            exp_check,
	input  wire dbus_pkg::word_t exp_rdata,
	input  wire logic            exp_err,
	output int                   error_count,
	output int                   done_count
);

	localparam int MAX_CYCLES = 3 * RESP_DELAY + 10;
	localparam dbus_pkg::addr_t TOP_ADDR = dbus_pkg::addr_t'(MEM_WORDS * 4);

	dbus_pkg::word_t model [MEM_WORDS];

	// Request in flight
	logic            pending;
	logic            p_we;
	dbus_pkg::addr_t p_addr;
	dbus_pkg::word_t p_wdata;
	dbus_pkg::strb_t p_wstrb;
	logic            p_chk;
	dbus_pkg::word_t p_exp_rdata;
	logic            p_exp_err;
	int              cycles;

	always @(posedge clk) begin : compare
		logic            in_range;
		logic            model_err;
		dbus_pkg::word_t model_rdata;
		int              idx;

		if (rst) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				model[i] = '0;
			end
			pending     = 1'b0;
			cycles      = 0;
			error_count = 0;
			done_count  = 0;
		end else begin
			if (pending) cycles++;
			if (done && !pending) begin
				$display("Error at %0t ns: done with no request outstanding", $time);
				error_count++;
			end else if (done) begin
				in_range    = p_addr < TOP_ADDR;
				model_err   = !in_range;
				model_rdata = '0;
				idx         = int'(p_addr >> 2);
				if (in_range && p_we) begin
					for (int b = 0; b < dbus_pkg::STRB_W; b++) begin
						if (p_wstrb[b]) model[idx][8*b +: 8] = p_wdata[8*b +: 8];
					end
				end else if (in_range) begin
					model_rdata = model[idx];
				end
				if (err !== model_err) begin
					$display("Mismatch at %0t ns: addr 0x%08h err %b, model %b",
						$time, p_addr, err, model_err);
					error_count++;
				end
				if (!p_we && rdata !== model_rdata) begin
					$display("Mismatch at %0t ns: load 0x%08h rdata 0x%08h, model 0x%08h",
						$time, p_addr, rdata, model_rdata);
					error_count++;
				end
				if (p_chk && (err !== p_exp_err || (!p_we && rdata !== p_exp_rdata))) begin
					$display("Mismatch at %0t ns: addr 0x%08h got 0x%08h/%b, table 0x%08h/%b",
						$time, p_addr, rdata, err, p_exp_rdata, p_exp_err);
					error_count++;
				end
				if (cycles > MAX_CYCLES) begin
					$display("Error at %0t ns: request to 0x%08h took %0d cycles, limit %0d",
						$time, p_addr, cycles, MAX_CYCLES);
					error_count++;
				end
				done_count++;
				pending = 1'b0;
			end
			if (req && !stall) begin
				pending     = 1'b1;
				cycles      = 0;
				p_we        = we;
				p_addr      = addr;
				p_wdata     = wdata;
				p_wstrb     = wstrb;
				p_chk       = exp_check;
				p_exp_rdata = exp_rdata;
				p_exp_err   = exp_err;
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/dbus_subsystem_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module dbus_subsystem_assert (
	input wire logic clk,
	input wire logic rst,
	input wire logic req,
	input wire logic stall,
	input wire logic done
);

	int   fail_count = 0;
	logic busy;

	// Set on an accepted request, cleared by its completion
	always @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
		end else if (done) begin
			busy <= 1'b0;
		end else if (req && !stall) begin
			busy <= 1'b1;
		end
	end

	stall_after_req: assert property (@(posedge clk) disable iff (rst)
		(req && !stall) |=> stall)
		else begin
			$error("stall low in the cycle after an accepted request");
			fail_count++;
		end

	stall_until_done: assert property (@(posedge clk) disable iff (rst)
		(stall && !done) |=> stall)
		else begin
			$error("stall dropped before done");
			fail_count++;
		end

	done_one_cycle: assert property (@(posedge clk) disable iff (rst)
		done |=> !done)
		else begin
			$error("done held for more than one cycle");
			fail_count++;
		end

	done_needs_req: assert property (@(posedge clk) disable iff (rst)
		done |-> busy)
		else begin
			$error("done without a preceding request");
			fail_count++;
		end

endmodule

`default_nettype wire

/* testbench/dbus_subsystem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module dbus_subsystem_tb;

	localparam int MEM_WORDS  = 256;
	localparam int RESP_DELAY = 2;
	localparam int PERIOD     = 100;
	localparam int N_RANDOM   = 40;

	localparam dbus_pkg::addr_t TOP_ADDR  = dbus_pkg::addr_t'(MEM_WORDS * 4);
	localparam dbus_pkg::addr_t LAST_ADDR = TOP_ADDR - 32'd4;
	// Random traffic stays in a 16-word window so loads hit earlier stores
	localparam dbus_pkg::addr_t RAND_BASE = dbus_pkg::addr_t'(MEM_WORDS * 2);

	typedef struct packed {
		logic            we;
		dbus_pkg::addr_t addr;
		dbus_pkg::word_t wdata;
		dbus_pkg::strb_t wstrb;
		logic            chk;
		dbus_pkg::word_t exp_rdata;
		logic            exp_err;
	} entry_t;

	logic            clk;
	logic            rst;
	logic            req;
	logic            we;
	dbus_pkg::addr_t addr;
	dbus_pkg::word_t wdata;
	dbus_pkg::strb_t wstrb;
	logic            stall;
	dbus_pkg::word_t rdata;
	logic            done;
	logic            err;
	logic            exp_check;
	dbus_pkg::word_t exp_rdata;
	logic            exp_err;
	int              check_errors;
	int              done_count;
	int              tb_errors;
	int              assert_errors;
	logic            table_ready;
	entry_t          table_q[$];

	dbus_subsystem_top #(
		.MEM_WORDS  (MEM_WORDS),
		.RESP_DELAY (RESP_DELAY)
	) dbus_subsystem_top_i (
		.clk   (clk),
		.rst   (rst),
		.req   (req),
		.we    (we),
		.addr  (addr),
		.wdata (wdata),
		.wstrb (wstrb),
		.stall (stall),
		.rdata (rdata),
		.done  (done),
		.err   (err)
	);

	dbus_checker #(
		.MEM_WORDS  (MEM_WORDS),
		.RESP_DELAY (RESP_DELAY)
	) dbus_checker_i (
		.clk         (clk),
		.rst         (rst),
		.req         (req),
		.we          (we),
		.addr        (addr),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.stall       (stall),
		.done        (done),
		.rdata       (rdata),
		.err         (err),
		.exp_check   (exp_check),
		.exp_rdata   (exp_rdata),
		.exp_err     (exp_err),
		.error_count (check_errors),
		.done_count  (done_count)
	);

	bind uncached_bridge dbus_subsystem_assert bridge_assert_i (
		.clk   (clk),
		.rst   (rst),
		.req   (req),
		.stall (stall),
		.done  (done)
	);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic add_entry(
		input logic            e_we,
		input dbus_pkg::addr_t e_addr,
		input dbus_pkg::word_t e_wdata,
		input dbus_pkg::strb_t e_wstrb,
		input logic            e_chk,
		input dbus_pkg::word_t e_rdata,
		input logic            e_err
	);
		entry_t e;
		e.we        = e_we;
		e.addr      = e_addr;
		e.wdata     = e_wdata;
		e.wstrb     = e_wstrb;
		e.chk       = e_chk;
		e.exp_rdata = e_rdata;
		e.exp_err   = e_err;
		table_q.push_back(e);
	endtask

	task automatic build_table;
		logic [31:0] rnd;
		logic [31:0] data;
		int          i;
		rnd = 32'hdd3c_eb8d;
		// Full-word store then load
		add_entry(1'b1, 32'h10, 32'hdead_beef, 4'hf, 1'b1, 32'h0, 1'b0);
		add_entry(1'b0, 32'h10, 32'h0, 4'hf, 1'b1, 32'hdead_beef, 1'b0);
		// Byte and halfword merges
		add_entry(1'b1, 32'h20, 32'h1122_3344, 4'hf, 1'b1, 32'h0, 1'b0);
		add_entry(1'b1, 32'h20, 32'h0000_00aa, 4'b0001, 1'b1, 32'h0, 1'b0);
		add_entry(1'b1, 32'h20, 32'hbbcc_0000, 4'b1100, 1'b1, 32'h0, 1'b0);
		add_entry(1'b0, 32'h20, 32'h0, 4'hf, 1'b1, 32'hbbcc_33aa, 1'b0);
		add_entry(1'b1, 32'h24, 32'h5566_ee77, 4'b0010, 1'b1, 32'h0, 1'b0);
		add_entry(1'b0, 32'h24, 32'h0, 4'hf, 1'b1, 32'h0000_ee00, 1'b0);
		// Never written
		add_entry(1'b0, 32'hf0, 32'h0, 4'hf, 1'b1, 32'h0, 1'b0);
		// Beyond the array
		add_entry(1'b1, TOP_ADDR, 32'h1234_5678, 4'hf, 1'b1, 32'h0, 1'b1);
		add_entry(1'b0, TOP_ADDR, 32'h0, 4'hf, 1'b1, 32'h0, 1'b1);
		add_entry(1'b1, 32'h8000_0010, 32'h0bad_0bad, 4'hf, 1'b1, 32'h0, 1'b1);
		add_entry(1'b0, 32'h0, 32'h0, 4'hf, 1'b1, 32'h0, 1'b0);
		add_entry(1'b0, 32'h10, 32'h0, 4'hf, 1'b1, 32'hdead_beef, 1'b0);
		add_entry(1'b1, LAST_ADDR, 32'hcafe_f00d, 4'hf, 1'b1, 32'h0, 1'b0);
		add_entry(1'b0, LAST_ADDR, 32'h0, 4'hf, 1'b1, 32'hcafe_f00d, 1'b0);
		// Random stores and loads against the checker's model
		for (i = 0; i < N_RANDOM; i++) begin
			rnd  = xorshift32(rnd);
			data = xorshift32(rnd);
			rnd  = data;
			add_entry(rnd[16], RAND_BASE + {26'd0, rnd[3:0], 2'b00}, data, rnd[11:8],
				rnd[16], 32'h0, 1'b0);
		end
	endtask

	task automatic run_entry(input entry_t e);
		while (stall) @(negedge clk);
		req       = 1'b1;
		we        = e.we;
		addr      = e.addr;
		wdata     = e.wdata;
		wstrb     = e.wstrb;
		exp_check = e.chk;
		exp_rdata = e.exp_rdata;
		exp_err   = e.exp_err;
		@(negedge clk);
		req = 1'b0;
		while (!done) @(negedge clk);
	endtask

	// Watchdog sized from the table length
	initial begin
		wait (table_ready);
		#((table_q.size() * (3 * RESP_DELAY + 10) + 20) * PERIOD);
		$display("Run timed out before all requests completed");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int i;
		rst         = 1'b1;
		req         = 1'b0;
		we          = 1'b0;
		addr        = '0;
		wdata       = '0;
		wstrb       = '0;
		exp_check   = 1'b0;
		exp_rdata   = '0;
		exp_err     = 1'b0;
		tb_errors   = 0;
		table_ready = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		for (i = 0; i < table_q.size(); i++) begin
			run_entry(table_q[i]);
		end
		// Let the checker see the last done
		repeat (2) @(negedge clk);
		if (done_count != table_q.size()) begin
			$display("Only %0d of %0d requests completed", done_count, table_q.size());
			tb_errors++;
		end
		assert_errors = dbus_subsystem_top_i.uncached_bridge_i.bridge_assert_i.fail_count;
		$display("Errors: %0d checker, %0d assertion, %0d testbench",
			check_errors, assert_errors, tb_errors);
		if (check_errors == 0 && assert_errors == 0 && tb_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
